// File: include/icache_params.svh
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// Cache geometry
`define ICACHE_INDEX_W    8
`define ICACHE_TAG_W      20
`define ICACHE_OFFSET_W   4
`define ICACHE_WORD_W     32
`define ICACHE_LINE_WORDS 4

`define ICACHE_LINE_W     (`ICACHE_WORD_W * `ICACHE_LINE_WORDS)
`define ICACHE_SETS       (1 << `ICACHE_INDEX_W)   // Direct mapped with one line per set

// AXI read channel widths
`define AXI_ADDR_W        32
`define AXI_DATA_W        32
`define AXI_LEN_W         8   // Beats minus one

`endif

// File: source/cache_pkg.sv
package cache_pkg;

`include "icache_params.svh"

    typedef logic [`ICACHE_INDEX_W-1:0]  cache_index_t;
    typedef logic [`ICACHE_TAG_W-1:0]    cache_tag_t;
    typedef logic [`ICACHE_OFFSET_W-1:0] cache_offset_t;   // Byte within the line
    typedef logic [`ICACHE_WORD_W-1:0]   word_t;
    typedef logic [`ICACHE_LINE_W-1:0]   line_t;           // Word 0 in the low bits

    // Fetch request as the IFU splits it
    typedef struct packed {
        cache_index_t  index;
        cache_tag_t    tag;
        cache_offset_t offset;
        logic          uncache;
    } cache_req_t;

    // Refill kind toward the bridge
    typedef enum logic [2:0] {
        RD_WORD = 3'b010,
        RD_LINE = 3'b100
    } rd_type_e;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        REFILL,
        RESPOND
    } icache_state_e;

endpackage

// File: source/axi_pkg.sv
package axi_pkg;

`include "icache_params.svh"

    typedef logic [`AXI_ADDR_W-1:0] axi_addr_t;
    typedef logic [`AXI_LEN_W-1:0]  axi_len_t;    // Burst length minus one

    // AR channel payload for an INCR burst of 4-byte beats
    typedef struct packed {
        axi_addr_t addr;
        axi_len_t  len;
    } axi_ar_t;

    typedef struct packed {
        logic [`AXI_DATA_W-1:0] data;
        logic                   last;
    } axi_r_t;

    typedef enum logic [1:0] {
        BR_IDLE,
        BR_ADDR,
        BR_DATA
    } bridge_state_e;

endpackage

// File: source/icache_line_store.sv
`timescale 1ns/1ps

`include "icache_params.svh"

module icache_line_store (
    input  logic                    aclk,
    input  logic                    rst_n,
    // Lookup port
    input  cache_pkg::cache_index_t lookup_index,
    input  cache_pkg::cache_tag_t   lookup_tag,
    output logic                    hit,
    output cache_pkg::line_t        hit_line,
    // Fill port uses the lookup index and tag
    input  logic                    fill_en,
    input  cache_pkg::line_t        fill_line
);

    logic [`ICACHE_SETS-1:0] valid;
    cache_pkg::cache_tag_t   tag_ram  [`ICACHE_SETS];
    cache_pkg::line_t        data_ram [`ICACHE_SETS];

    cache_pkg::cache_tag_t   stored_tag;
    logic                    entry_valid;

    // Valid bit set by a line fill
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (fill_en) begin
            valid[lookup_index] <= 1'b1;
        end
    end

    // Tag and data written together on a fill
    // An older line at this index is simply replaced
    always_ff @(posedge aclk) begin
        if (fill_en) begin
            tag_ram[lookup_index]  <= lookup_tag;
            data_ram[lookup_index] <= fill_line;
        end
    end

    // Zero-cycle lookup
    assign stored_tag  = tag_ram[lookup_index];
    assign entry_valid = valid[lookup_index];

    assign hit      = entry_valid && (stored_tag == lookup_tag);
    assign hit_line = data_ram[lookup_index];   // Only meaningful when hit

endmodule

// File: source/icache_ctrl.sv
`timescale 1ns/1ps

`include "icache_params.svh"

module icache_ctrl (
    input  logic                    aclk,
    input  logic                    rst_n,
    // CPU side
    input  logic                    req_valid,
    input  cache_pkg::cache_req_t   req,
    output logic                    addr_ok,
    output logic                    data_ok,
    output cache_pkg::word_t        rdata,
    // Line store side
    output cache_pkg::cache_index_t lookup_index,
    output cache_pkg::cache_tag_t   lookup_tag,
    input  logic                    hit,
    input  cache_pkg::line_t        hit_line,
    output logic                    fill_en,
    output cache_pkg::line_t        fill_line,
    // Bridge side
    output logic                    rd_req,
    output cache_pkg::rd_type_e     rd_type,
    output axi_pkg::axi_addr_t      rd_addr,
    input  logic                    rd_rdy,
    input  logic                    ret_valid,
    input  logic                    ret_last,
    input  cache_pkg::word_t        ret_data
);

    localparam int BYTE_W = $clog2(`ICACHE_WORD_W / 8);     // Byte bits inside a word
    localparam int SEL_W  = $clog2(`ICACHE_LINE_WORDS);     // Word select bits

    cache_pkg::icache_state_e state;
    cache_pkg::icache_state_e state_nxt;
    cache_pkg::cache_req_t    req_r;        // Held from accept until data_ok
    cache_pkg::line_t         line_buf;     // Newest beat at the top
    cache_pkg::cache_offset_t word_offset;
    cache_pkg::cache_offset_t rd_offset;
    cache_pkg::word_t         resp_word;
    logic                     lookup_hit;

    function automatic cache_pkg::word_t pick_word(input cache_pkg::line_t      line,
                                                   input cache_pkg::cache_offset_t offset);
        logic [SEL_W-1:0] sel;
        sel = offset[BYTE_W +: SEL_W];
        return line[sel * `ICACHE_WORD_W +: `ICACHE_WORD_W];
    endfunction

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cache_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            cache_pkg::IDLE: begin
                if (req_valid) state_nxt = cache_pkg::LOOKUP;
            end
            cache_pkg::LOOKUP: begin
                // Uncached reads never look at the tag result
                if (!req_r.uncache && hit) state_nxt = cache_pkg::IDLE;
                else                       state_nxt = cache_pkg::MISS;
            end
            cache_pkg::MISS: begin
                if (rd_rdy) state_nxt = cache_pkg::REFILL;
            end
            cache_pkg::REFILL: begin
                if (ret_valid && ret_last) state_nxt = cache_pkg::RESPOND;
            end
            cache_pkg::RESPOND: state_nxt = cache_pkg::IDLE;
            default:            state_nxt = cache_pkg::IDLE;
        endcase
    end

    // Request capture on the accepting edge
    always_ff @(posedge aclk) begin
        if (addr_ok) begin
            req_r <= req;
        end
    end

    // Beats shift in from the top so word 0 ends up lowest
    always_ff @(posedge aclk) begin
        if (state == cache_pkg::REFILL && ret_valid) begin
            line_buf <= fill_line;
        end
    end

    assign addr_ok = (state == cache_pkg::IDLE) && req_valid;

    assign lookup_index = req_r.index;
    assign lookup_tag   = req_r.tag;
    assign lookup_hit   = (state == cache_pkg::LOOKUP) && !req_r.uncache && hit;

    // Line fill on the last beat of a cached refill
    assign fill_line = {ret_data, line_buf[`ICACHE_LINE_W-1:`ICACHE_WORD_W]};
    assign fill_en   = (state == cache_pkg::REFILL) && ret_valid && ret_last && !req_r.uncache;

    // Line refills start at the line base, uncached reads at the word
    assign word_offset = {req_r.offset[`ICACHE_OFFSET_W-1:BYTE_W], {BYTE_W{1'b0}}};
    assign rd_offset   = req_r.uncache ? word_offset : '0;

    assign rd_req  = (state == cache_pkg::MISS);
    assign rd_type = req_r.uncache ? cache_pkg::RD_WORD : cache_pkg::RD_LINE;
    assign rd_addr = {req_r.tag, req_r.index, rd_offset};

    // A single uncached beat sits in the top word
    assign resp_word = req_r.uncache ? line_buf[`ICACHE_LINE_W-1 -: `ICACHE_WORD_W]
                                     : pick_word(line_buf, req_r.offset);

    assign data_ok = lookup_hit || (state == cache_pkg::RESPOND);
    assign rdata   = (state == cache_pkg::RESPOND) ? resp_word
                                                   : pick_word(hit_line, req_r.offset);

endmodule

// File: source/axi_read_bridge.sv
`timescale 1ns/1ps

`include "icache_params.svh"

module axi_read_bridge (
    input  logic                aclk,
    input  logic                rst_n,
    // Cache read request
    input  logic                rd_req,
    input  cache_pkg::rd_type_e rd_type,
    input  axi_pkg::axi_addr_t  rd_addr,
    output logic                rd_rdy,
    // Beats back to the cache
    output logic                ret_valid,
    output logic                ret_last,
    output cache_pkg::word_t    ret_data,
    // AXI AR
    output logic                arvalid,
    output axi_pkg::axi_ar_t    ar,
    input  logic                arready,
    // AXI R
    input  logic                rvalid,
    input  axi_pkg::axi_r_t     r,
    output logic                rready
);

    localparam axi_pkg::axi_len_t LINE_LEN = axi_pkg::axi_len_t'(`ICACHE_LINE_WORDS - 1);

    axi_pkg::bridge_state_e state;
    axi_pkg::axi_addr_t     addr_r;
    axi_pkg::axi_len_t      len_r;
    logic                   take_req;
    logic                   r_beat;

    assign take_req = rd_req && rd_rdy;
    assign r_beat   = rvalid && rready;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state <= axi_pkg::BR_IDLE;
        end else begin
            case (state)
                axi_pkg::BR_IDLE: if (take_req) state <= axi_pkg::BR_ADDR;
                axi_pkg::BR_ADDR: if (arready)  state <= axi_pkg::BR_DATA;
                axi_pkg::BR_DATA: begin
                    if (r_beat && r.last) state <= axi_pkg::BR_IDLE;   // Burst done
                end
                default: state <= axi_pkg::BR_IDLE;
            endcase
        end
    end

    // Burst parameters latched with the request
    always_ff @(posedge aclk) begin
        if (take_req) begin
            addr_r <= rd_addr;
            len_r  <= (rd_type == cache_pkg::RD_LINE) ? LINE_LEN : '0;
        end
    end

    assign rd_rdy = (state == axi_pkg::BR_IDLE);

    // AR held stable in BR_ADDR until arready
    assign arvalid = (state == axi_pkg::BR_ADDR);
    assign ar.addr = addr_r;
    assign ar.len  = len_r;

    assign rready = (state == axi_pkg::BR_DATA);

    assign ret_valid = r_beat;
    assign ret_last  = r_beat && r.last;
    assign ret_data  = r.data;

endmodule

// File: source/icache_top.sv
`timescale 1ns/1ps

module icache_top (
    input  logic                  aclk,
    input  logic                  rst_n,
    // Fetch side
    input  logic                  req_valid,
    input  cache_pkg::cache_req_t req,
    output logic                  addr_ok,
    output logic                  data_ok,
    output cache_pkg::word_t      rdata,
    // AXI read
    output logic                  arvalid,
    output axi_pkg::axi_ar_t      ar,
    input  logic                  arready,
    input  logic                  rvalid,
    input  axi_pkg::axi_r_t       r,
    output logic                  rready
);

    // Controller to line store
    cache_pkg::cache_index_t lookup_index;
    cache_pkg::cache_tag_t   lookup_tag;
    logic                    hit;
    cache_pkg::line_t        hit_line;
    logic                    fill_en;
    cache_pkg::line_t        fill_line;

    // Controller to bridge
    logic                    rd_req;
    cache_pkg::rd_type_e     rd_type;
    axi_pkg::axi_addr_t      rd_addr;
    logic                    rd_rdy;
    logic                    ret_valid;
    logic                    ret_last;
    cache_pkg::word_t        ret_data;

    icache_ctrl u_ctrl (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req          (req),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .rdata        (rdata),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .hit          (hit),
        .hit_line     (hit_line),
        .fill_en      (fill_en),
        .fill_line    (fill_line),
        .rd_req       (rd_req),
        .rd_type      (rd_type),
        .rd_addr      (rd_addr),
        .rd_rdy       (rd_rdy),
        .ret_valid    (ret_valid),
        .ret_last     (ret_last),
        .ret_data     (ret_data)
    );

    icache_line_store u_store (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .hit          (hit),
        .hit_line     (hit_line),
        .fill_en      (fill_en),
        .fill_line    (fill_line)
    );

    axi_read_bridge u_bridge (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .rd_req       (rd_req),
        .rd_type      (rd_type),
        .rd_addr      (rd_addr),
        .rd_rdy       (rd_rdy),
        .ret_valid    (ret_valid),
        .ret_last     (ret_last),
        .ret_data     (ret_data),
        .arvalid      (arvalid),
        .ar           (ar),
        .arready      (arready),
        .rvalid       (rvalid),
        .r            (r),
        .rready       (rready)
    );

endmodule

// File: verif/icache_asserts.sv
`timescale 1ns/1ps

module icache_asserts (
    input logic                  aclk,
    input logic                  rst_n,
    input logic                  req_valid,
    input logic                  addr_ok,
    input logic                  data_ok,
    input logic                  arvalid,
    input axi_pkg::axi_ar_t      ar,
    input logic                  arready,
    input logic                  rvalid,
    input axi_pkg::axi_r_t       r,
    input logic                  rready
);

    logic outstanding;   // Request accepted, data_ok still to come
    logic ar_pending;    // AR accepted, last R beat still to come

    int   ar_stable_fails;
    int   data_ok_fails;
    int   rready_fails;
    int   addr_ok_fails;
    int   fail_count;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            outstanding <= 1'b0;
        end else if (req_valid && addr_ok) begin
            outstanding <= 1'b1;
        end else if (data_ok) begin
            outstanding <= 1'b0;
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            ar_pending <= 1'b0;
        end else if (arvalid && arready) begin
            ar_pending <= 1'b1;
        end else if (rvalid && rready && r.last) begin
            ar_pending <= 1'b0;
        end
    end

    assign fail_count = ar_stable_fails + data_ok_fails + rready_fails + addr_ok_fails;

    // AR must hold until the slave takes it
    a_ar_stable: assert property (@(posedge aclk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(ar))
    else begin
        $error("AR changed or dropped while arready was low");
        ar_stable_fails++;
    end

    a_data_ok_busy: assert property (@(posedge aclk) disable iff (!rst_n)
        data_ok |-> outstanding)
    else begin
        $error("data_ok raised with no request in flight");
        data_ok_fails++;
    end

    a_rready_after_ar: assert property (@(posedge aclk) disable iff (!rst_n)
        rready |-> ar_pending)
    else begin
        $error("rready raised with no AR outstanding");
        rready_fails++;
    end

    a_addr_ok_idle: assert property (@(posedge aclk) disable iff (!rst_n)
        addr_ok |-> !outstanding)
    else begin
        $error("addr_ok raised while a request was in flight");
        addr_ok_fails++;
    end

endmodule

bind icache_top icache_asserts u_asserts (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .addr_ok   (addr_ok),
    .data_ok   (data_ok),
    .arvalid   (arvalid),
    .ar        (ar),
    .arready   (arready),
    .rvalid    (rvalid),
    .r         (r),
    .rready    (rready)
);

// File: verif/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;

    localparam int          TIMEOUT_CYCLES = 200;
    localparam logic [31:0] SEED           = 32'hc45bf92b;
    localparam logic [31:0] MEM_XOR        = 32'h5a5a0000;

    logic                  aclk = 1'b0;
    logic                  rst_n;
    logic                  req_valid;
    cache_pkg::cache_req_t req;
    logic                  addr_ok;
    logic                  data_ok;
    cache_pkg::word_t      rdata;
    logic                  arvalid;
    axi_pkg::axi_ar_t      ar;
    logic                  arready;
    logic                  rvalid;
    axi_pkg::axi_r_t       r;
    logic                  rready;

    // AXI slave model
    axi_pkg::axi_ar_t      ar_log[$];     // Every AR the model accepted
    logic                  stall_en;      // Random arready delay and rvalid gaps
    logic                  burst_active;
    axi_pkg::axi_ar_t      burst;
    axi_pkg::axi_len_t     beat_idx;
    integer                model_seed;
    integer                stim_seed;

    int                    error_count;
    int                    timeout_count;

    icache_top uut (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .arvalid   (arvalid),
        .ar        (ar),
        .arready   (arready),
        .rvalid    (rvalid),
        .r         (r),
        .rready    (rready)
    );

    always #20 aclk = ~aclk;

    // Memory content rule
    function automatic cache_pkg::word_t mem_word(input axi_pkg::axi_addr_t addr);
        return addr ^ MEM_XOR;
    endfunction

    function automatic cache_pkg::cache_req_t make_req(input axi_pkg::axi_addr_t addr,
                                                       input logic uncache);
        cache_pkg::cache_req_t req_f;
        req_f.tag     = addr[31:12];
        req_f.index   = addr[11:4];
        req_f.offset  = addr[3:0];
        req_f.uncache = uncache;
        return req_f;
    endfunction

    // Line reads start at the 16-byte boundary with four beats
    function automatic axi_pkg::axi_ar_t expected_ar(input axi_pkg::axi_addr_t addr,
                                                     input logic line);
        axi_pkg::axi_ar_t exp_ar;
        exp_ar.addr = line ? (addr & 32'hffff_fff0) : addr;
        exp_ar.len  = line ? 8'd3 : 8'd0;
        return exp_ar;
    endfunction

    // Slave outputs all change on the falling edge
    initial begin
        logic [31:0] rnd;
        model_seed   = SEED;
        arready      = 1'b0;
        rvalid       = 1'b0;
        r            = '0;
        burst_active = 1'b0;
        burst        = '0;
        beat_idx     = '0;
        forever begin
            @(negedge aclk);
            rnd = $random(model_seed);
            if (rvalid) begin   // Shown only while rready is high so always taken
                if (r.last) burst_active = 1'b0;
                beat_idx = beat_idx + 8'd1;
            end
            arready = 1'b0;
            rvalid  = 1'b0;
            if (!rst_n) begin
                burst_active = 1'b0;
            end else if (!burst_active && arvalid) begin
                if (!stall_en || rnd[1:0] == 2'b00) begin
                    arready = 1'b1;
                    ar_log.push_back(ar);
                    burst        = ar;
                    beat_idx     = '0;
                    burst_active = 1'b1;
                end
            end else if (burst_active && rready) begin
                if (!stall_en || rnd[3:2] != 2'b00) begin
                    rvalid = 1'b1;
                    r.data = mem_word(burst.addr + {22'b0, beat_idx, 2'b00});
                    r.last = (beat_idx == burst.len);
                end
            end
        end
    end

    task automatic check_word(input string name, input cache_pkg::word_t got,
                              input cache_pkg::word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_ar(input string name, input axi_pkg::axi_ar_t got,
                            input axi_pkg::axi_ar_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got addr %h len %0d expected addr %h len %0d",
                     $time, name, got.addr, got.len, exp.addr, exp.len);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic expect_single_ar(input string name, input int base,
                                    input axi_pkg::axi_ar_t exp);
        check_count({name, " AR count"}, ar_log.size() - base, 1);
        if (ar_log.size() > base) check_ar({name, " AR"}, ar_log[base], exp);
    endtask

    // One fetch; cycles counts falling edges from acceptance to data_ok
    task automatic fetch(input axi_pkg::axi_addr_t addr, input logic uncache,
                         output cache_pkg::word_t data, output int cycles);
        int waited;
        waited = 0;
        cycles = 0;
        data   = '0;
        @(negedge aclk);
        req_valid = 1'b1;
        req       = make_req(addr, uncache);
        #1;                 // addr_ok is combinational
        while (!addr_ok && waited < TIMEOUT_CYCLES) begin
            @(negedge aclk);
            #1;
            waited++;
        end
        if (!addr_ok) begin
            $display("Timeout: the read of %h was never accepted", addr);
            timeout_count++;
            @(negedge aclk);
            req_valid = 1'b0;
            return;
        end
        // The requester keeps req_valid high until its data returns
        @(negedge aclk);
        cycles = 1;
        while (!data_ok && cycles < TIMEOUT_CYCLES) begin
            @(negedge aclk);
            cycles++;
        end
        req_valid = 1'b0;
        if (!data_ok) begin
            $display("Timeout: no data_ok for the read of %h", addr);
            timeout_count++;
            return;
        end
        data = rdata;
    endtask

    task automatic test_reset();
        cache_pkg::word_t data;
        int               cycles;
        repeat (10) begin
            @(negedge aclk);
            check_bit("data_ok in reset", data_ok, 1'b0);
            check_bit("arvalid in reset", arvalid, 1'b0);
            check_bit("rready in reset", rready, 1'b0);
        end
        rst_n = 1'b1;
        repeat (2) begin
            @(negedge aclk);
            check_bit("data_ok after reset", data_ok, 1'b0);
            check_bit("arvalid after reset", arvalid, 1'b0);
            check_bit("rready after reset", rready, 1'b0);
        end
        fetch(32'h0000_2040, 1'b0, data, cycles);
        check_word("rdata first read", data, mem_word(32'h0000_2040));
    endtask

    task automatic test_cold_miss();
        cache_pkg::word_t data;
        int               cycles;
        int               base;
        base = ar_log.size();
        fetch(32'h1234_5678, 1'b0, data, cycles);
        check_word("rdata cold miss", data, mem_word(32'h1234_5678));
        expect_single_ar("cold miss", base, expected_ar(32'h1234_5678, 1'b1));
    endtask

    task automatic test_hit();
        cache_pkg::word_t   data;
        int                 cycles;
        int                 base;
        axi_pkg::axi_addr_t addr;
        base = ar_log.size();
        for (int i = 0; i < 4; i++) begin
            if (i != 2) begin   // Word 2 was the miss
                addr = 32'h1234_5670 + 32'(i * 4);
                fetch(addr, 1'b0, data, cycles);
                check_word("rdata hit", data, mem_word(addr));
                check_count("hit latency", cycles, 1);
            end
        end
        check_count("AR count on hits", ar_log.size() - base, 0);
    endtask

    task automatic test_uncached();
        cache_pkg::word_t data;
        int               cycles;
        int               base;
        base = ar_log.size();
        fetch(32'h0008_1234, 1'b1, data, cycles);
        check_word("rdata uncached", data, mem_word(32'h0008_1234));
        expect_single_ar("uncached", base, expected_ar(32'h0008_1234, 1'b0));
        // A cached read of the same line must miss
        base = ar_log.size();
        fetch(32'h0008_1234, 1'b0, data, cycles);
        check_word("rdata after uncached", data, mem_word(32'h0008_1234));
        expect_single_ar("after uncached", base, expected_ar(32'h0008_1234, 1'b1));
    endtask

    task automatic test_conflict();
        cache_pkg::word_t data;
        int               cycles;
        int               base;
        base = ar_log.size();
        fetch(32'h0abc_d678, 1'b0, data, cycles);   // Index 0x67 with another tag
        check_word("rdata conflict", data, mem_word(32'h0abc_d678));
        expect_single_ar("conflict", base, expected_ar(32'h0abc_d678, 1'b1));
        base = ar_log.size();
        fetch(32'h1234_5678, 1'b0, data, cycles);
        check_word("rdata evicted line", data, mem_word(32'h1234_5678));
        expect_single_ar("evicted line", base, expected_ar(32'h1234_5678, 1'b1));
    endtask

    task automatic test_backpressure();
        cache_pkg::word_t   data;
        int                 cycles;
        logic [31:0]        rnd;
        axi_pkg::axi_addr_t addr;
        stall_en = 1'b1;
        for (int n = 0; n < 40; n++) begin
            rnd = $random(stim_seed);
            // Four tags over four indexes so hits and evictions mix
            addr = {12'h400, 6'h0, rnd[1:0], 6'h0, rnd[5:4], rnd[9:8], 2'b00};
            fetch(addr, rnd[12:11] == 2'b00, data, cycles);
            check_word($sformatf("rdata random read %0d", n), data, mem_word(addr));
        end
        stall_en = 1'b0;
    endtask

    initial begin
        rst_n         = 1'b0;
        req_valid     = 1'b0;
        req           = '0;
        stall_en      = 1'b0;
        stim_seed     = SEED;
        error_count   = 0;
        timeout_count = 0;

        test_reset();
        test_cold_miss();
        test_hit();
        test_uncached();
        test_conflict();
        test_backpressure();

        repeat (2) @(negedge aclk);
        $display("Check errors: %0d, timeouts: %0d, assertion failures: %0d",
                 error_count, timeout_count, uut.u_asserts.fail_count);
        if (error_count == 0 && timeout_count == 0 && uut.u_asserts.fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
source/cache_pkg.sv
source/axi_pkg.sv
source/icache_line_store.sv
source/icache_ctrl.sv
source/axi_read_bridge.sv
source/icache_top.sv
verif/icache_asserts.sv
verif/icache_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f vlog.f --top-module icache_tb -Mdir "$BUILD_DIR" -o icache_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/icache_sim" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
exit 0
